/* sources.f */
+incdir+include
rtl/hmacPkg.sv
rtl/shaCompress.sv
rtl/jobQueue.sv
rtl/hmacSequencer.sv
rtl/hmacPostscrypt.sv
test/hmacTb.sv

/* Makefile */
# Verilator build and run of the HMAC post-scrypt testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/VhmacTb

obj_dir/VhmacTb: sources.f rtl/*.sv include/*.svh test/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module hmacTb -f sources.f

# exit status of the simulation is the test result
run: obj_dir/VhmacTb
	./obj_dir/VhmacTb

clean:
	rm -rf obj_dir

/* include/hmacRef.svh */
// HMAC reference model
// SHA-256 over byte messages and the expected result of one job
`ifndef HMAC_REF_SVH
`define HMAC_REF_SVH

function automatic hmacPkg::wordT refRotr(input hmacPkg::wordT x, input int unsigned n);
	return (x >> n) | (x << (32 - n));
endfunction

// sigma helper, last term shifted or rotated
function automatic hmacPkg::wordT refMix(input hmacPkg::wordT x, input int unsigned a,
	input int unsigned b, input int unsigned c, input bit shiftLast);
	return refRotr(x, a) ^ refRotr(x, b) ^ (shiftLast ? (x >> c) : refRotr(x, c));
endfunction

function automatic hmacPkg::digestT refCompress(input hmacPkg::digestT chain,
	input hmacPkg::blockT blk);
	hmacPkg::wordT w [64];
	hmacPkg::wordT v [8];
	hmacPkg::wordT t1;
	hmacPkg::wordT t2;
	hmacPkg::digestT res;
	for (int i = 0; i < 16; i++) w[i] = blk.words[i];
	// full schedule up front
	for (int i = 16; i < 64; i++) begin
		w[i] = refMix(w[i-2], 17, 19, 10, 1'b1) + w[i-7]
			+ refMix(w[i-15], 7, 18, 3, 1'b1) + w[i-16];
	end
	for (int i = 0; i < 8; i++) v[i] = chain[i];
	for (int i = 0; i < 64; i++) begin
		t1 = v[7] + refMix(v[4], 6, 11, 25, 1'b0) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
			+ hmacPkg::SHA_K[i] + w[i];
		t2 = refMix(v[0], 2, 13, 22, 1'b0) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int j = 7; j > 0; j--) v[j] = v[j-1];
		v[4] = v[4] + t1;
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++) res[i] = chain[i] + v[i];
	return res;
endfunction

// plain SHA-256 with standard padding
function automatic hmacPkg::digestT refSha(input logic [7:0] msg [$]);
	logic [7:0] data [$];
	logic [63:0] bitLen;
	hmacPkg::digestT h;
	hmacPkg::blockT blk;
	data = msg;
	bitLen = 64'(msg.size()) * 64'd8;
	data.push_back(8'h80);
	while (data.size() % 64 != 56) data.push_back(8'h00);
	for (int i = 7; i >= 0; i--) data.push_back(bitLen[8*i +: 8]);
	h = hmacPkg::SHA_INIT;
	for (int b = 0; b < data.size() / 64; b++) begin
		for (int i = 0; i < 64; i++) blk.bytes[i] = data[64*b + i];
		h = refCompress(h, blk);
	end
	return h;
endfunction

// expected result, key is the pad, message is payload then block index
function automatic hmacPkg::hmacResultT refHmac(input hmacPkg::hmacJobT job);
	logic [7:0] key [64];
	logic [7:0] inner [$];
	logic [7:0] outer [$];
	hmacPkg::wordT index;
	hmacPkg::digestT innerDigest;
	hmacPkg::hmacResultT res;
	index = hmacPkg::BLOCK_INDEX;
	for (int i = 0; i < 64; i++) key[i] = (i < 32) ? job.pad[i/4][8*(3-i%4) +: 8] : 8'h00;
	for (int i = 0; i < 64; i++) inner.push_back(key[i] ^ hmacPkg::IPAD_WORD[7:0]);
	for (int i = 0; i < 128; i++) inner.push_back(job.payload[i]);
	for (int i = 0; i < 4; i++) inner.push_back(index[8*(3-i) +: 8]);
	innerDigest = refSha(inner);
	for (int i = 0; i < 64; i++) outer.push_back(key[i] ^ hmacPkg::OPAD_WORD[7:0]);
	for (int i = 0; i < 32; i++) outer.push_back(innerDigest[i/4][8*(3-i%4) +: 8]);
	res.job = job.job;
	res.nonce = job.nonce;
	res.digest = refSha(outer);
	return res;
endfunction

`endif

/* test/hmacTb.sv */
// HMAC post-scrypt testbench
// random and corner jobs checked against the reference HMAC in order
module hmacTb;

	timeunit 1ns;
	timeprecision 1ps;

	`include "hmacRef.svh"

	// accepted jobs over all tests
	// each job takes six 66-cycle compressions
	localparam int JOB_COUNT = 20;
	localparam int JOB_CYCLES = 6 * (hmacPkg::SHA_ROUNDS + 2);
	localparam int CYCLE_LIMIT = JOB_COUNT * JOB_CYCLES + 500;

	logic clk;
	logic rstN;
	logic doWork;
	hmacPkg::hmacJobT work;
	logic queueFull;
	hmacPkg::hmacResultT result;
	logic resultAvailable;

	// expected results in push order
	hmacPkg::hmacResultT expected [$];
	hmacPkg::hmacResultT want;
	hmacPkg::wordT rngState = 32'd25129;
	hmacPkg::wordT nextTag = 32'd1;
	int cycles = 0;
	int acceptCount = 0;
	int dropCount = 0;
	int resultCount = 0;

	hmacPostscrypt dut (
		.clk(clk),
		.rstN(rstN),
		.doWork(doWork),
		.work(work),
		.queueFull(queueFull),
		.result(result),
		.resultAvailable(resultAvailable)
	);

	always #10 clk = ~clk;

	task automatic failRun(input string why);
		$display("Checks failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input logic [255:0] actual,
		input logic [255:0] expectedValue);
		if (actual !== expectedValue) begin
			$display("error at %0t: %s expected %h actual %h", $time, name, expectedValue,
				actual);
			failRun("value mismatch");
		end
	endtask

	function automatic hmacPkg::wordT xorshift(input hmacPkg::wordT x);
		hmacPkg::wordT y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every word random before the running tag overwrites the job word
	task automatic randomJob(output hmacPkg::hmacJobT j);
		for (int i = 0; i < 42; i++) begin
			rngState = xorshift(rngState);
			j[32*i +: 32] = rngState;
		end
		j.job = nextTag;
		nextTag++;
	endtask

	// one strobe per call
	// jobs offered while the queue is full get no expected result
	task automatic pushJob(input hmacPkg::hmacJobT j, output bit accepted);
		@(negedge clk);
		doWork = 1'b1;
		work = j;
		accepted = !queueFull;
		if (accepted) begin
			expected.push_back(refHmac(j));
			acceptCount++;
		end else begin
			dropCount++;
		end
	endtask

	task automatic releaseWork();
		@(negedge clk);
		doWork = 1'b0;
	endtask

	task automatic waitDrain();
		while (expected.size() != 0) @(negedge clk);
	endtask

	// compare on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (rstN && resultAvailable) begin
			if (expected.size() == 0) begin
				failRun("a result came back with no job outstanding");
			end else begin
				want = expected.pop_front();
				check("result.job", result.job, want.job);
				check("result.nonce", result.nonce, want.nonce);
				check("result.digest", result.digest, want.digest);
				resultCount++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			failRun("timeout, results did not arrive within the cycle limit");
		end
	end

	initial begin
		hmacPkg::hmacJobT j;
		bit accepted;
		int gap;
		clk = 1'b0;
		rstN = 1'b0;
		doWork = 1'b0;
		work = '0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;

		// quiet after reset
		repeat (100) begin
			@(negedge clk);
			check("resultAvailable", resultAvailable, 1'b0);
			check("queueFull", queueFull, 1'b0);
		end

		// single job
		randomJob(j);
		pushJob(j, accepted);
		releaseWork();
		waitDrain();

		// four back to back
		repeat (4) begin
			randomJob(j);
			pushJob(j, accepted);
		end
		releaseWork();
		waitDrain();

		// fill the queue behind a running job and push two that must be lost
		randomJob(j);
		pushJob(j, accepted);
		releaseWork();
		repeat (3) @(negedge clk);
		gap = acceptCount;
		accepted = 1'b1;
		while (accepted) begin
			randomJob(j);
			pushJob(j, accepted);
		end
		randomJob(j);
		pushJob(j, accepted);
		releaseWork();
		check("accepted while running", acceptCount - gap, hmacPkg::QUEUE_DEPTH);
		check("dropped pushes", dropCount, 2);
		waitDrain();

		// zero and all-ones pads over a zero payload
		j = '0;
		j.job = 32'h0000_0a00;
		j.nonce = 32'h0;
		pushJob(j, accepted);
		j.job = 32'h0000_0a01;
		j.nonce = 32'hffff_ffff;
		j.pad = '1;
		pushJob(j, accepted);
		releaseWork();
		waitDrain();

		// random gaps with a wait for room so none is lost
		repeat (8) begin
			rngState = xorshift(rngState);
			gap = int'(rngState % 32);
			repeat (gap) @(negedge clk);
			while (queueFull) @(negedge clk);
			randomJob(j);
			pushJob(j, accepted);
			releaseWork();
		end
		waitDrain();

		check("results received", resultCount, JOB_COUNT);
		$display("All checks passed");
		$finish;
	end

endmodule

/* rtl/hmacPostscrypt.sv */
// HMAC post-scrypt top
// job queue, sequencer and iterative SHA-256 engine
module hmacPostscrypt (
	input logic clk,
	input logic rstN,
	input logic doWork,
	input hmacPkg::hmacJobT work,
	output logic queueFull,
	output hmacPkg::hmacResultT result,
	output logic resultAvailable
);

	hmacPkg::hmacJobT queueHead;
	logic queueEmpty;
	logic pop;

	// sequencer to engine
	logic start;
	hmacPkg::blockT block;
	hmacPkg::digestT chainIn;
	logic done;
	hmacPkg::digestT chainOut;

	jobQueue queue (
		.clk(clk),
		.rstN(rstN),
		.push(doWork),
		.pop(pop),
		.in(work),
		.head(queueHead),
		.empty(queueEmpty),
		.full(queueFull)
	);

	hmacSequencer sequencer (
		.clk(clk),
		.rstN(rstN),
		.head(queueHead),
		.empty(queueEmpty),
		.pop(pop),
		.start(start),
		.block(block),
		.chainIn(chainIn),
		.done(done),
		.chainOut(chainOut),
		.result(result),
		.resultAvailable(resultAvailable)
	);

	shaCompress engine (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.block(block),
		.chainIn(chainIn),
		.done(done),
		.chainOut(chainOut)
	);

endmodule

/* rtl/hmacSequencer.sv */
// HMAC sequencer
// runs the six compressions of one job and registers its result
module hmacSequencer (
	input logic clk,
	input logic rstN,
	input hmacPkg::hmacJobT head,
	input logic empty,
	output logic pop,
	output logic start,
	output hmacPkg::blockT block,
	output hmacPkg::digestT chainIn,
	input logic done,
	input hmacPkg::digestT chainOut,
	output hmacPkg::hmacResultT result,
	output logic resultAvailable
);

	// a job is in flight
	logic running;
	logic [hmacPkg::STAGE_W-1:0] stage;
	// start of the following stage, one cycle after done
	logic startNext;

	hmacPkg::hmacJobT jobReg;
	hmacPkg::digestT innerDigest;
	// job feeding the block, head while it is being popped
	hmacPkg::hmacJobT src;

	function automatic logic [hmacPkg::STAGE_W-1:0] nextStage(
		input logic [hmacPkg::STAGE_W-1:0] cur
	);
		case (cur)
			hmacPkg::STAGE_IPAD: return hmacPkg::STAGE_LOW;
			hmacPkg::STAGE_LOW: return hmacPkg::STAGE_HIGH;
			hmacPkg::STAGE_HIGH: return hmacPkg::STAGE_TAIL;
			hmacPkg::STAGE_TAIL: return hmacPkg::STAGE_OPAD;
			hmacPkg::STAGE_OPAD: return hmacPkg::STAGE_OUTER;
			default: return hmacPkg::STAGE_IPAD;
		endcase
	endfunction

	assign pop = !running && !empty;
	assign start = pop || startNext;
	assign src = pop ? head : jobReg;

	// pad stages restart from the initial digest
	assign chainIn = (stage == hmacPkg::STAGE_IPAD || stage == hmacPkg::STAGE_OPAD)
		? hmacPkg::SHA_INIT : chainOut;

	// block assembly per stage
	always_comb begin
		block = '0;
		case (stage)
			hmacPkg::STAGE_IPAD: begin
				block.words[0:7] = src.pad ^ {8{hmacPkg::IPAD_WORD}};
				block.words[8:15] = {8{hmacPkg::IPAD_WORD}};
			end
			hmacPkg::STAGE_LOW: block.bytes = src.payload[0:63];
			hmacPkg::STAGE_HIGH: block.bytes = src.payload[64:127];
			hmacPkg::STAGE_TAIL: begin
				// index word, end marker, inner length
				block.words[0] = hmacPkg::BLOCK_INDEX;
				block.bytes[4] = 8'h80;
				block.bytes[62:63] = 16'(hmacPkg::INNER_BITS);
			end
			hmacPkg::STAGE_OPAD: begin
				block.words[0:7] = src.pad ^ {8{hmacPkg::OPAD_WORD}};
				block.words[8:15] = {8{hmacPkg::OPAD_WORD}};
			end
			hmacPkg::STAGE_OUTER: begin
				// inner digest padded to one block
				block.words[0:7] = innerDigest;
				block.bytes[32] = 8'h80;
				block.bytes[62:63] = 16'(hmacPkg::OUTER_BITS);
			end
			default: block = '0;
		endcase
	end

	// stage control
	always_ff @(posedge clk) begin
		if (!rstN) begin
			running <= 1'b0;
			stage <= hmacPkg::STAGE_IPAD;
			startNext <= 1'b0;
			resultAvailable <= 1'b0;
		end else begin
			startNext <= 1'b0;
			resultAvailable <= 1'b0;
			if (pop) begin
				running <= 1'b1;
			end else if (done) begin
				if (stage == hmacPkg::STAGE_OUTER) begin
					// job finished, back to idle with ipad ready
					running <= 1'b0;
					stage <= hmacPkg::STAGE_IPAD;
					resultAvailable <= 1'b1;
				end else begin
					stage <= nextStage(stage);
					startNext <= 1'b1;
				end
			end
		end
	end

	// job, inner digest and result
	always_ff @(posedge clk) begin
		if (pop) begin
			jobReg <= head;
		end
		if (done && stage == hmacPkg::STAGE_TAIL) begin
			innerDigest <= chainOut;
		end
		if (done && stage == hmacPkg::STAGE_OUTER) begin
			result.job <= jobReg.job;
			result.nonce <= jobReg.nonce;
			result.digest <= chainOut;
		end
	end

	doneWhileIdle: assert property (@(posedge clk) disable iff (!rstN) done |-> running && !start)
		else $error("compression done without a running stage");

endmodule

/* rtl/jobQueue.sv */
// HMAC job queue
// circular buffer of jobs, oldest entry shown at head
module jobQueue (
	input logic clk,
	input logic rstN,
	input logic push,
	input logic pop,
	input hmacPkg::hmacJobT in,
	output hmacPkg::hmacJobT head,
	output logic empty,
	output logic full
);

	hmacPkg::hmacJobT entries [hmacPkg::QUEUE_DEPTH];

	logic [$clog2(hmacPkg::QUEUE_DEPTH)-1:0] rdPtr;
	logic [$clog2(hmacPkg::QUEUE_DEPTH)-1:0] wrPtr;
	logic [$clog2(hmacPkg::QUEUE_DEPTH+1)-1:0] count;

	// push into a full queue is lost
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign empty = (count == '0);
	assign full = (int'(count) == hmacPkg::QUEUE_DEPTH);
	assign head = entries[rdPtr];

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (int'(wrPtr) == hmacPkg::QUEUE_DEPTH - 1) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (int'(rdPtr) == hmacPkg::QUEUE_DEPTH - 1) ? '0 : rdPtr + 1'b1;
			end
			// simultaneous push and pop keep the count
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (doPush) begin
			entries[wrPtr] <= in;
		end
	end

	popWhileEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
		else $error("job popped from an empty queue");

endmodule

/* rtl/shaCompress.sv */
// SHA-256 compression engine
// one round per clock over a 16-word schedule window, chaining add at the end
module shaCompress (
	input logic clk,
	input logic rstN,
	input logic start,
	input hmacPkg::blockT block,
	input hmacPkg::digestT chainIn,
	output logic done,
	output hmacPkg::digestT chainOut
);

	// round in progress
	logic busy;
	logic [$clog2(hmacPkg::SHA_ROUNDS)-1:0] round;

	// working variables a..h, a in word 0
	hmacPkg::digestT work;
	// chaining digest kept for the final add
	hmacPkg::digestT savedChain;
	// schedule window, word 0 is w[t] of the current round
	hmacPkg::wordT [0:15] window;

	hmacPkg::wordT temp1;
	hmacPkg::wordT temp2;
	hmacPkg::wordT nextWord;

	function automatic hmacPkg::wordT rotr(input hmacPkg::wordT x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic hmacPkg::wordT bigSigma0(input hmacPkg::wordT x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic hmacPkg::wordT bigSigma1(input hmacPkg::wordT x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic hmacPkg::wordT smallSigma0(input hmacPkg::wordT x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic hmacPkg::wordT smallSigma1(input hmacPkg::wordT x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// round math on the current working state
	always_comb begin
		temp1 = work[7] + bigSigma1(work[4])
			+ ((work[4] & work[5]) ^ (~work[4] & work[6]))
			+ hmacPkg::SHA_K[round] + window[0];
		temp2 = bigSigma0(work[0])
			+ ((work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]));
		// w[t+16] from the window
		nextWord = smallSigma1(window[14]) + window[9] + smallSigma0(window[1]) + window[0];
	end

	// round counter and done pulse
	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			round <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				round <= '0;
			end else if (busy) begin
				round <= round + 1'b1;
				// last round, sum becomes visible next cycle
				if (int'(round) == hmacPkg::SHA_ROUNDS - 1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// working state and schedule
	always_ff @(posedge clk) begin
		if (start) begin
			work <= chainIn;
			savedChain <= chainIn;
			window <= block.words;
		end else if (busy) begin
			work <= {temp1 + temp2, work[0], work[1], work[2],
				work[3] + temp1, work[4], work[5], work[6]};
			window <= {window[1:15], nextWord};
		end
	end

	// final add, holds while the working state is frozen
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			chainOut[i] = savedChain[i] + work[i];
		end
	end

	startWhileBusy: assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
		else $error("compression started while a block is still running");

endmodule

/* rtl/hmacPkg.sv */
// HMAC post-scrypt package
// SHA-256 and HMAC constants, job and result types, block views
package hmacPkg;

	// one SHA word
	typedef logic [31:0] wordT;

	// word 0 sits in the most significant position
	typedef wordT [0:7] digestT;

	// one 512-bit block, decoded as words for the schedule and as bytes for assembly
	typedef union packed {
		wordT [0:15] words;
		logic [0:63][7:0] bytes;
	} blockT;

	// incoming job, payload low half first
	typedef struct packed {
		wordT job;
		wordT nonce;
		digestT pad;
		logic [0:127][7:0] payload;
	} hmacJobT;

	// returned digest with the tags of its job
	typedef struct packed {
		wordT job;
		wordT nonce;
		digestT digest;
	} hmacResultT;

	localparam digestT SHA_INIT = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// round constants, entry 0 first
	localparam wordT [0:63] SHA_K = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam int SHA_ROUNDS = 64;

	// hmac pad patterns
	localparam wordT IPAD_WORD = 32'h36363636;
	localparam wordT OPAD_WORD = 32'h5c5c5c5c;

	// block index word appended to the payload
	localparam wordT BLOCK_INDEX = 32'h00000001;

	// message lengths in bits, ipad block + payload + index, opad block + digest
	localparam int unsigned INNER_BITS = 1568;
	localparam int unsigned OUTER_BITS = 768;

	localparam int QUEUE_DEPTH = 4;

	// compression stages of one job, in issue order
	localparam int STAGE_W = 3;
	localparam logic [STAGE_W-1:0] STAGE_IPAD = 3'd0;
	localparam logic [STAGE_W-1:0] STAGE_LOW = 3'd1;
	localparam logic [STAGE_W-1:0] STAGE_HIGH = 3'd2;
	localparam logic [STAGE_W-1:0] STAGE_TAIL = 3'd3;
	localparam logic [STAGE_W-1:0] STAGE_OPAD = 3'd4;
	localparam logic [STAGE_W-1:0] STAGE_OUTER = 3'd5;

endpackage
